// ==== source/soc_params.svh ====
`ifndef SOC_PARAMS_SVH
`define SOC_PARAMS_SVH

//////////////////////////////////////////////////
// Bus widths
//////////////////////////////////////////////////
`define SOC_ADDR_WIDTH          32
`define SOC_DATA_WIDTH          32
`define SOC_BE_WIDTH            4

// Region field and region map
`define SOC_REGION_MSB          31
`define SOC_REGION_LSB          28
`define SOC_REGION_RAM          0
`define SOC_REGION_UART         1

// Data RAM of 1 KB
`define SOC_RAM_WORDS           256
`define SOC_RAM_IDX_WIDTH       8

//////////////////////////////////////////////////
// UART
//////////////////////////////////////////////////
`define SOC_UART_REG_TXDATA     0
`define SOC_UART_REG_STATUS     1
`define SOC_UART_REG_BAUD       2
`define SOC_UART_DIV_WIDTH      16
`define SOC_UART_DIV_RESET      8
`define SOC_UART_FRAME_BITS     10   // start + 8 data + stop

`endif

// ==== source/soc_pkg.sv ====
`include "soc_params.svh"

package soc_pkg;

    // Memory view with region, word address and byte offset
    typedef struct packed {
        logic [`SOC_REGION_MSB-`SOC_REGION_LSB:0] region;
        logic [`SOC_REGION_LSB-3:0]               word_addr;
        logic [1:0]                               byte_off;
    } soc_mem_addr_t;

    // Peripheral view with region, unused gap, register index and byte offset
    typedef struct packed {
        logic [`SOC_REGION_MSB-`SOC_REGION_LSB:0] region;
        logic [`SOC_REGION_LSB-7:0]               unused;
        logic [3:0]                               reg_idx;
        logic [1:0]                               byte_off;
    } soc_periph_addr_t;

    // One bus address word decoded per target type
    typedef union packed {
        soc_mem_addr_t    mem;
        soc_periph_addr_t periph;
    } soc_addr_u;

endpackage

// ==== source/soc_uart_tx.sv ====
`include "soc_params.svh"

module soc_uart_tx (
    input  logic                           clk_i,
    input  logic                           reset_i,
    input  logic                           tx_start_i,
    input  logic [7:0]                     tx_byte_i,
    input  logic [`SOC_UART_DIV_WIDTH-1:0] baud_div_i,
    output logic                           tx_busy_o,
    output logic                           uart_tx_o
);

    localparam int BIT_CNT_WIDTH = $clog2(`SOC_UART_FRAME_BITS);

    logic [`SOC_UART_FRAME_BITS-1:0] frame_q;
    logic [`SOC_UART_DIV_WIDTH-1:0]  baud_cnt_q;
    logic [BIT_CNT_WIDTH-1:0]        bit_cnt_q;
    logic                            busy_q;
    logic [`SOC_UART_DIV_WIDTH-1:0]  div_eff;
    logic                            bit_done;
    logic                            last_bit;

    // Divider of zero runs at one cycle per bit
    assign div_eff  = (baud_div_i == '0) ? `SOC_UART_DIV_WIDTH'(1) : baud_div_i;
    assign bit_done = busy_q && (baud_cnt_q == div_eff - `SOC_UART_DIV_WIDTH'(1));
    assign last_bit = bit_cnt_q == BIT_CNT_WIDTH'(`SOC_UART_FRAME_BITS - 1);

    //////////////////////////////////////////////////
    // Frame shifter
    //////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            frame_q    <= '1;
            baud_cnt_q <= '0;
            bit_cnt_q  <= '0;
            busy_q     <= 1'b0;
        end else if (tx_start_i && !busy_q) begin
            // Stop, data LSB first, start
            frame_q    <= {1'b1, tx_byte_i, 1'b0};
            baud_cnt_q <= '0;
            bit_cnt_q  <= '0;
            busy_q     <= 1'b1;
        end else if (busy_q) begin
            if (bit_done) begin
                baud_cnt_q <= '0;
                frame_q    <= {1'b1, frame_q[`SOC_UART_FRAME_BITS-1:1]};
                if (last_bit)
                    busy_q <= 1'b0;
                else
                    bit_cnt_q <= bit_cnt_q + BIT_CNT_WIDTH'(1);
            end else begin
                baud_cnt_q <= baud_cnt_q + `SOC_UART_DIV_WIDTH'(1);
            end
        end
    end

    // Line idles high once the frame has shifted out
    assign uart_tx_o = frame_q[0];
    assign tx_busy_o = busy_q;

endmodule

// ==== source/soc_uart_regs.sv ====
`include "soc_params.svh"

module soc_uart_regs (
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  logic                          req_i,
    input  logic                          we_i,
    input  logic [`SOC_ADDR_WIDTH-1:0]    addr_i,
    input  logic [`SOC_DATA_WIDTH-1:0]    wdata_i,
    input  logic                          tx_busy_i,
    output logic                          ack_o,
    output logic [`SOC_DATA_WIDTH-1:0]    rdata_o,
    output logic                          tx_start_o,
    output logic [7:0]                    tx_byte_o,
    output logic [`SOC_UART_DIV_WIDTH-1:0] baud_div_o
);

    logic                           ack_q;
    logic                           access;
    logic                           tx_start_q;
    logic [7:0]                     tx_byte_q;
    logic [`SOC_UART_DIV_WIDTH-1:0] baud_q;
    logic [`SOC_DATA_WIDTH-1:0]     rdata_q;
    logic [`SOC_DATA_WIDTH-1:0]     rd_mux;
    logic [3:0]                     reg_idx;
    soc_pkg::soc_addr_u             reg_addr;

    assign reg_addr = addr_i;
    assign reg_idx  = reg_addr.periph.reg_idx;
    assign access   = req_i & ~ack_q;

    //////////////////////////////////////////////////
    // Read mux
    //////////////////////////////////////////////////
    always_comb begin
        case (reg_idx)
            4'(`SOC_UART_REG_STATUS):
                rd_mux = {{(`SOC_DATA_WIDTH-1){1'b0}}, tx_busy_i};
            4'(`SOC_UART_REG_BAUD):
                rd_mux = {{(`SOC_DATA_WIDTH-`SOC_UART_DIV_WIDTH){1'b0}}, baud_q};
            default:
                rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ack_q      <= 1'b0;
            tx_start_q <= 1'b0;
            baud_q     <= `SOC_UART_DIV_WIDTH'(`SOC_UART_DIV_RESET);
        end else begin
            ack_q      <= req_i;
            tx_start_q <= 1'b0;
            if (access && we_i) begin
                // Bytes written while busy are dropped
                if (reg_idx == 4'(`SOC_UART_REG_TXDATA) && !tx_busy_i && !tx_start_q)
                    tx_start_q <= 1'b1;
                if (reg_idx == 4'(`SOC_UART_REG_BAUD))
                    baud_q <= wdata_i[`SOC_UART_DIV_WIDTH-1:0];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (access && we_i && reg_idx == 4'(`SOC_UART_REG_TXDATA))
            tx_byte_q <= wdata_i[7:0];
        if (access && !we_i)
            rdata_q <= rd_mux;
    end

    assign ack_o      = ack_q;
    assign rdata_o    = rdata_q;
    assign tx_start_o = tx_start_q;
    assign tx_byte_o  = tx_byte_q;
    assign baud_div_o = baud_q;

endmodule

// ==== source/soc_data_ram.sv ====
`include "soc_params.svh"

module soc_data_ram (
    input  logic                       clk_i,
    input  logic                       reset_i,
    input  logic                       req_i,
    input  logic                       we_i,
    input  logic [`SOC_BE_WIDTH-1:0]   be_i,
    input  logic [`SOC_ADDR_WIDTH-1:0] addr_i,
    input  logic [`SOC_DATA_WIDTH-1:0] wdata_i,
    output logic                       ack_o,
    output logic [`SOC_DATA_WIDTH-1:0] rdata_o
);

    logic [`SOC_DATA_WIDTH-1:0]   mem [0:`SOC_RAM_WORDS-1];
    logic [`SOC_DATA_WIDTH-1:0]   rdata_q;
    logic                         ack_q;
    logic                         access;
    logic [`SOC_RAM_IDX_WIDTH-1:0] word_idx;
    soc_pkg::soc_addr_u           ram_addr;

    assign ram_addr = addr_i;

    // Upper word address bits alias onto the low index
    assign word_idx = ram_addr.mem.word_addr[`SOC_RAM_IDX_WIDTH-1:0];

    // One access per link cycle on the rising edge of ack
    assign access = req_i & ~ack_q;

    always_ff @(posedge clk_i) begin
        if (reset_i)
            ack_q <= 1'b0;
        else
            ack_q <= req_i;
    end

    //////////////////////////////////////////////////
    // Storage
    //////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (access && we_i) begin
            for (int b = 0; b < `SOC_BE_WIDTH; b++) begin
                if (be_i[b])
                    mem[word_idx][8*b +: 8] <= wdata_i[8*b +: 8];
            end
        end
        if (access && !we_i)
            rdata_q <= mem[word_idx];
    end

    assign ack_o   = ack_q;
    assign rdata_o = rdata_q;

endmodule

// ==== source/soc_bus_ctrl.sv ====
`include "soc_params.svh"

module soc_bus_ctrl (
    input  logic                       clk_i,
    input  logic                       reset_i,

    // Core data port
    input  logic                       core_req_i,
    input  logic                       core_we_i,
    input  logic [`SOC_BE_WIDTH-1:0]   core_be_i,
    input  logic [`SOC_ADDR_WIDTH-1:0] core_addr_i,
    input  logic [`SOC_DATA_WIDTH-1:0] core_wdata_i,
    output logic                       core_gnt_o,
    output logic                       core_rvalid_o,
    output logic [`SOC_DATA_WIDTH-1:0] core_rdata_o,
    output logic                       core_err_o,

    // Target links
    output logic                       ram_req_o,
    output logic                       uart_req_o,
    output logic                       link_we_o,
    output logic [`SOC_BE_WIDTH-1:0]   link_be_o,
    output logic [`SOC_ADDR_WIDTH-1:0] link_addr_o,
    output logic [`SOC_DATA_WIDTH-1:0] link_wdata_o,
    input  logic                       ram_ack_i,
    input  logic [`SOC_DATA_WIDTH-1:0] ram_rdata_i,
    input  logic                       uart_ack_i,
    input  logic [`SOC_DATA_WIDTH-1:0] uart_rdata_i
);

    localparam logic [2:0] S_IDLE    = 3'd0;
    localparam logic [2:0] S_GRANT   = 3'd1;
    localparam logic [2:0] S_REQUEST = 3'd2;
    localparam logic [2:0] S_RELEASE = 3'd3;
    localparam logic [2:0] S_RESPOND = 3'd4;

    logic [2:0]                 state_q;
    logic [2:0]                 state_d;
    logic                       sel_ram_q;
    logic                       sel_uart_q;
    logic                       err_q;
    logic                       we_q;
    logic [`SOC_BE_WIDTH-1:0]   be_q;
    logic [`SOC_ADDR_WIDTH-1:0] addr_q;
    logic [`SOC_DATA_WIDTH-1:0] wdata_q;
    logic [`SOC_DATA_WIDTH-1:0] rdata_q;

    soc_pkg::soc_addr_u         req_addr;
    logic                       hit_ram;
    logic                       hit_uart;
    logic                       link_ack;
    logic [`SOC_DATA_WIDTH-1:0] link_rdata;

    //////////////////////////////////////////////////
    // Region decode
    //////////////////////////////////////////////////
    assign req_addr = core_addr_i;
    assign hit_ram  = req_addr.mem.region == 4'(`SOC_REGION_RAM);
    assign hit_uart = req_addr.mem.region == 4'(`SOC_REGION_UART);

    assign link_ack   = (sel_ram_q & ram_ack_i) | (sel_uart_q & uart_ack_i);
    assign link_rdata = sel_ram_q ? ram_rdata_i : uart_rdata_i;

    //////////////////////////////////////////////////
    // FSM
    //////////////////////////////////////////////////
    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE:
                if (core_req_i)
                    state_d = S_GRANT;
            S_GRANT:
                state_d = (hit_ram || hit_uart) ? S_REQUEST : S_RESPOND;
            S_REQUEST:
                if (link_ack)
                    state_d = S_RELEASE;
            // Wait for the target to drop ack
            S_RELEASE:
                if (!link_ack)
                    state_d = S_RESPOND;
            S_RESPOND:
                state_d = S_IDLE;
            default:
                state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q    <= S_IDLE;
            sel_ram_q  <= 1'b0;
            sel_uart_q <= 1'b0;
            err_q      <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == S_GRANT) begin
                sel_ram_q  <= hit_ram;
                sel_uart_q <= hit_uart;
                err_q      <= !(hit_ram || hit_uart);
            end
        end
    end

    // Request capture and read data
    always_ff @(posedge clk_i) begin
        if (state_q == S_GRANT) begin
            we_q    <= core_we_i;
            be_q    <= core_be_i;
            addr_q  <= core_addr_i;
            wdata_q <= core_wdata_i;
            rdata_q <= '0;
        end else if (state_q == S_REQUEST && link_ack && !we_q) begin
            rdata_q <= link_rdata;
        end
    end

    assign core_gnt_o    = state_q == S_GRANT;
    assign core_rvalid_o = state_q == S_RESPOND;
    assign core_rdata_o  = rdata_q;
    assign core_err_o    = core_rvalid_o & err_q;

    assign ram_req_o    = (state_q == S_REQUEST) & sel_ram_q;
    assign uart_req_o   = (state_q == S_REQUEST) & sel_uart_q;
    assign link_we_o    = we_q;
    assign link_be_o    = be_q;
    assign link_addr_o  = addr_q;
    assign link_wdata_o = wdata_q;

endmodule

// ==== source/soc_top.sv ====
`include "soc_params.svh"

module soc_top (
    input  logic                       clk_i,
    input  logic                       reset_i,

    input  logic                       core_req_i,
    input  logic                       core_we_i,
    input  logic [`SOC_BE_WIDTH-1:0]   core_be_i,
    input  logic [`SOC_ADDR_WIDTH-1:0] core_addr_i,
    input  logic [`SOC_DATA_WIDTH-1:0] core_wdata_i,
    output logic                       core_gnt_o,
    output logic                       core_rvalid_o,
    output logic [`SOC_DATA_WIDTH-1:0] core_rdata_o,
    output logic                       core_err_o,

    output logic                       uart_tx_o
);

    //////////////////////////////////////////////////
    // Link and UART wires
    //////////////////////////////////////////////////
    logic                           ram_req;
    logic                           uart_req;
    logic                           link_we;
    logic [`SOC_BE_WIDTH-1:0]       link_be;
    logic [`SOC_ADDR_WIDTH-1:0]     link_addr;
    logic [`SOC_DATA_WIDTH-1:0]     link_wdata;
    logic                           ram_ack;
    logic [`SOC_DATA_WIDTH-1:0]     ram_rdata;
    logic                           uart_ack;
    logic [`SOC_DATA_WIDTH-1:0]     uart_rdata;
    logic                           tx_start;
    logic [7:0]                     tx_byte;
    logic [`SOC_UART_DIV_WIDTH-1:0] baud_div;
    logic                           tx_busy;

    soc_bus_ctrl bus_ctrl_inst (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .core_req_i    (core_req_i),
        .core_we_i     (core_we_i),
        .core_be_i     (core_be_i),
        .core_addr_i   (core_addr_i),
        .core_wdata_i  (core_wdata_i),
        .core_gnt_o    (core_gnt_o),
        .core_rvalid_o (core_rvalid_o),
        .core_rdata_o  (core_rdata_o),
        .core_err_o    (core_err_o),
        .ram_req_o     (ram_req),
        .uart_req_o    (uart_req),
        .link_we_o     (link_we),
        .link_be_o     (link_be),
        .link_addr_o   (link_addr),
        .link_wdata_o  (link_wdata),
        .ram_ack_i     (ram_ack),
        .ram_rdata_i   (ram_rdata),
        .uart_ack_i    (uart_ack),
        .uart_rdata_i  (uart_rdata)
    );

    soc_data_ram data_ram_inst (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .req_i   (ram_req),
        .we_i    (link_we),
        .be_i    (link_be),
        .addr_i  (link_addr),
        .wdata_i (link_wdata),
        .ack_o   (ram_ack),
        .rdata_o (ram_rdata)
    );

    soc_uart_regs uart_regs_inst (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .req_i      (uart_req),
        .we_i       (link_we),
        .addr_i     (link_addr),
        .wdata_i    (link_wdata),
        .tx_busy_i  (tx_busy),
        .ack_o      (uart_ack),
        .rdata_o    (uart_rdata),
        .tx_start_o (tx_start),
        .tx_byte_o  (tx_byte),
        .baud_div_o (baud_div)
    );

    soc_uart_tx uart_tx_inst (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .tx_start_i (tx_start),
        .tx_byte_i  (tx_byte),
        .baud_div_i (baud_div),
        .tx_busy_o  (tx_busy),
        .uart_tx_o  (uart_tx_o)
    );

endmodule

// ==== tb/tb_soc_top.sv ====
`include "soc_params.svh"

module tb_soc_top;

    localparam int BUS_TIMEOUT  = 100;
    localparam int UART_TIMEOUT = 400;

    logic        clk_i;
    logic        reset_i;
    logic        core_req_i;
    logic        core_we_i;
    logic [3:0]  core_be_i;
    logic [31:0] core_addr_i;
    logic [31:0] core_wdata_i;
    logic        core_gnt_o;
    logic        core_rvalid_o;
    logic [31:0] core_rdata_o;
    logic        core_err_o;
    logic        uart_tx_o;

    logic [31:0] ram_model [0:`SOC_RAM_WORDS-1];
    logic [7:0]  rx_byte;
    integer      seed;

    soc_top soc_top_inst (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .core_req_i    (core_req_i),
        .core_we_i     (core_we_i),
        .core_be_i     (core_be_i),
        .core_addr_i   (core_addr_i),
        .core_wdata_i  (core_wdata_i),
        .core_gnt_o    (core_gnt_o),
        .core_rvalid_o (core_rvalid_o),
        .core_rdata_o  (core_rdata_o),
        .core_err_o    (core_err_o),
        .uart_tx_o     (uart_tx_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////
    task automatic fail_stop(input string what);
        $display("%s", what);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string test_name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else
            fail_stop($sformatf("Mismatch %s: expected %h, actual %h",
                                test_name, expected, actual));
    endtask

    function automatic logic [31:0] ram_addr(input logic [7:0] idx);
        return {4'(`SOC_REGION_RAM), 18'h0, idx, 2'b00};
    endfunction

    function automatic logic [31:0] uart_addr(input int reg_idx);
        return {4'(`SOC_REGION_UART), 22'h0, 4'(reg_idx), 2'b00};
    endfunction

    // Bytes with their enable set come from the new word
    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0] be);
        logic [31:0] result;
        for (int b = 0; b < 4; b++)
            result[8*b +: 8] = be[b] ? new_word[8*b +: 8] : old_word[8*b +: 8];
        return result;
    endfunction

    task automatic next_drive_slot();
        @(posedge clk_i);
        #1;
    endtask

    //////////////////////////////////////////////////
    // Core data port
    //////////////////////////////////////////////////
    task automatic bus_access(input logic we, input logic [3:0] be, input logic [31:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        int cycles;
        core_req_i   = 1'b1;
        core_we_i    = we;
        core_be_i    = be;
        core_addr_i  = addr;
        core_wdata_i = wdata;
        cycles = 0;
        @(negedge clk_i);
        while (!core_gnt_o) begin
            cycles++;
            assert (cycles < BUS_TIMEOUT) else fail_stop("Bus controller never granted");
            @(negedge clk_i);
        end
        next_drive_slot();
        core_req_i = 1'b0;
        core_we_i  = 1'b0;
        cycles = 0;
        @(negedge clk_i);
        while (!core_rvalid_o) begin
            cycles++;
            assert (cycles < BUS_TIMEOUT) else fail_stop("No response after the grant");
            @(negedge clk_i);
        end
        rdata = core_rdata_o;
        err   = core_err_o;
        next_drive_slot();
    endtask

    task automatic bus_write(input string test_name, input logic [31:0] addr,
                             input logic [3:0] be, input logic [31:0] data);
        logic [31:0] rdata;
        logic        err;
        bus_access(1'b1, be, addr, data, rdata, err);
        check_value({test_name, " write err"}, 32'h0, 32'(err));
        check_value({test_name, " write rdata"}, 32'h0, rdata);
    endtask

    task automatic bus_read_check(input string test_name, input logic [31:0] addr,
                                  input logic [31:0] expected);
        logic [31:0] rdata;
        logic        err;
        bus_access(1'b0, 4'hF, addr, 32'h0, rdata, err);
        check_value({test_name, " read err"}, 32'h0, 32'(err));
        check_value(test_name, expected, rdata);
    endtask

    task automatic wait_uart_idle();
        logic [31:0] rdata;
        logic        err;
        int          polls;
        polls = 0;
        bus_access(1'b0, 4'hF, uart_addr(`SOC_UART_REG_STATUS), 32'h0, rdata, err);
        while (rdata[0]) begin
            polls++;
            assert (polls < BUS_TIMEOUT) else fail_stop("UART stayed busy");
            bus_access(1'b0, 4'hF, uart_addr(`SOC_UART_REG_STATUS), 32'h0, rdata, err);
        end
    endtask

    //////////////////////////////////////////////////
    // Serial line
    //////////////////////////////////////////////////
    task automatic uart_capture(input int div, output logic [7:0] data);
        int cycles;
        cycles = 0;
        @(negedge clk_i);
        while (uart_tx_o) begin
            cycles++;
            assert (cycles < UART_TIMEOUT) else fail_stop("No start bit on the serial line");
            @(negedge clk_i);
        end
        // Move to the middle of the start bit
        repeat (div / 2) @(negedge clk_i);
        assert (!uart_tx_o) else fail_stop("Start bit too short");
        for (int i = 0; i < 8; i++) begin
            repeat (div) @(negedge clk_i);
            data[i] = uart_tx_o;
        end
        repeat (div) @(negedge clk_i);
        assert (uart_tx_o) else fail_stop("Stop bit is not high");
    endtask

    task automatic line_quiet(input int cycles);
        repeat (cycles) begin
            @(negedge clk_i);
            assert (uart_tx_o) else fail_stop("Second start bit after the frame");
        end
    endtask

    //////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////
    task automatic test_reset_state();
        check_value("reset_line", 32'h1, 32'(uart_tx_o));
        bus_read_check("reset_status", uart_addr(`SOC_UART_REG_STATUS), 32'h0);
        bus_read_check("reset_baud", uart_addr(`SOC_UART_REG_BAUD), 32'(`SOC_UART_DIV_RESET));
    endtask

    task automatic test_ram_random();
        logic [7:0]  idx_list [20];
        logic [31:0] data;
        for (int i = 0; i < 20; i++) begin
            idx_list[i] = 8'($random(seed));
            data = $random(seed);
            ram_model[idx_list[i]] = data;
            bus_write("ram_random", ram_addr(idx_list[i]), 4'hF, data);
        end
        for (int i = 0; i < 20; i++)
            bus_read_check("ram_random", ram_addr(idx_list[i]), ram_model[idx_list[i]]);
    endtask

    task automatic test_byte_enables();
        logic [31:0] data;
        ram_model[8'h21] = 32'h1122_3344;
        bus_write("byte_en", ram_addr(8'h21), 4'hF, 32'h1122_3344);
        ram_model[8'h21] = merge_bytes(ram_model[8'h21], 32'hAABB_CCDD, 4'b0101);
        bus_write("byte_en", ram_addr(8'h21), 4'b0101, 32'hAABB_CCDD);
        bus_read_check("byte_en", ram_addr(8'h21), ram_model[8'h21]);
        // High word bits above the RAM index alias onto it
        data = $random(seed);
        ram_model[8'h47] = data;
        bus_write("alias", 32'h0ABC_D000 | ram_addr(8'h47), 4'hF, data);
        bus_read_check("alias", ram_addr(8'h47), data);
    endtask

    task automatic test_unmapped();
        logic [31:0] rdata;
        logic        err;
        bus_access(1'b0, 4'hF, 32'h2000_0040, 32'h0, rdata, err);
        check_value("region2_err", 32'h1, 32'(err));
        check_value("region2_rdata", 32'h0, rdata);
        bus_access(1'b1, 4'hF, 32'hF000_0010, 32'hDEAD_BEEF, rdata, err);
        check_value("region15_err", 32'h1, 32'(err));
        check_value("region15_rdata", 32'h0, rdata);
        bus_read_check("after_err", ram_addr(8'h21), ram_model[8'h21]);
    endtask

    task automatic test_uart_frame();
        bus_write("uart_baud", uart_addr(`SOC_UART_REG_BAUD), 4'hF, 32'd5);
        bus_read_check("uart_baud", uart_addr(`SOC_UART_REG_BAUD), 32'd5);
        fork
            uart_capture(5, rx_byte);
            begin
                bus_write("uart_tx", uart_addr(`SOC_UART_REG_TXDATA), 4'hF, 32'hA5);
                bus_read_check("uart_busy", uart_addr(`SOC_UART_REG_STATUS), 32'h1);
            end
        join
        next_drive_slot();
        check_value("uart_frame", 32'hA5, 32'(rx_byte));
        wait_uart_idle();
    endtask

    task automatic test_uart_busy_drop();
        fork
            begin
                uart_capture(5, rx_byte);
                line_quiet(`SOC_UART_FRAME_BITS * 5 + 5);
            end
            begin
                bus_write("busy_first", uart_addr(`SOC_UART_REG_TXDATA), 4'hF, 32'h3C);
                bus_write("busy_drop", uart_addr(`SOC_UART_REG_TXDATA), 4'hF, 32'hFF);
            end
        join
        next_drive_slot();
        check_value("busy_frame", 32'h3C, 32'(rx_byte));
        wait_uart_idle();
    endtask

    initial begin
        seed         = 14549;
        reset_i      = 1'b1;
        core_req_i   = 1'b0;
        core_we_i    = 1'b0;
        core_be_i    = 4'h0;
        core_addr_i  = 32'h0;
        core_wdata_i = 32'h0;
        repeat (10) @(posedge clk_i);
        #1;
        reset_i = 1'b0;

        test_reset_state();
        test_ram_random();
        test_byte_enables();
        test_unmapped();
        test_uart_frame();
        test_uart_busy_drop();

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+source
source/soc_pkg.sv
source/soc_uart_tx.sv
source/soc_uart_regs.sv
source/soc_data_ram.sv
source/soc_bus_ctrl.sv
source/soc_top.sv
tb/tb_soc_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Verilator build and run of tb_soc_top, result taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f vlog.f --top-module tb_soc_top -o tb_soc_top \
    > build.log 2>&1 && ./obj_dir/tb_soc_top > sim.log 2>&1
grep -q "SIMULATION PASSED" sim.log && echo "Simulation result: pass" || {
    echo "Simulation result: fail, see build.log and sim.log"
    exit 1
}
